//--- logic/mgt_stream_pkg.sv
// Stream beat, port number and device id types shared by the lanes, the top level and the bench
package mgt_stream_pkg;

  // ----------------------------------------------------------
  // Stream word
  // ----------------------------------------------------------
  localparam int STREAM_DW = 64;

  typedef logic [STREAM_DW-1:0] stream_data_t;

  // One beat on a router or transceiver word port
  typedef struct packed {
    logic         valid;
    logic         last;
    stream_data_t data;
  } stream_beat_t;

  // ----------------------------------------------------------
  // Discovery info
  // ----------------------------------------------------------
  localparam int PORT_NUM_W  = 8;
  localparam int DEVICE_ID_W = 16;

  // Lane port number, reported in the port info word
  typedef logic [PORT_NUM_W-1:0] port_num_t;

  // Device identifier, common to every lane
  typedef logic [DEVICE_ID_W-1:0] device_id_t;

endpackage

//--- logic/regport_pkg.sv
// Register port types, per-lane register map and block size, imported by the register path modules
package regport_pkg;

  localparam int REG_AW = 14;
  localparam int REG_DW = 32;

  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [REG_DW-1:0] reg_data_t;

  // Broadcast request, one-cycle pulses
  typedef struct packed {
    logic      wr_req;
    logic      rd_req;
    reg_addr_t addr;
    reg_data_t wr_data;
  } reg_req_t;

  typedef struct packed {
    logic      rd_resp;
    reg_data_t rd_data;
  } reg_rsp_t;

  // Host side of the register port
  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    reg_data_t wr_data;
  } host_req_t;

  typedef struct packed {
    logic      valid;
    logic      timeout;
    reg_data_t rd_data;
  } host_rsp_t;

  // ----------------------------------------------------------
  // Lane register map
  // ----------------------------------------------------------
  localparam int REG_BLOCK_SIZE = 16;

  localparam reg_addr_t REG_CTRL       = reg_addr_t'(0);
  localparam reg_addr_t REG_STATUS     = reg_addr_t'(1);
  localparam reg_addr_t REG_TX_COUNT   = reg_addr_t'(2);
  localparam reg_addr_t REG_RX_COUNT   = reg_addr_t'(3);
  localparam reg_addr_t REG_DROP_COUNT = reg_addr_t'(4);
  localparam reg_addr_t REG_PORT_INFO  = reg_addr_t'(5);

  // Returned when no lane claims a read
  localparam reg_data_t TIMEOUT_DATA = 32'hDEAD_BEEF;

endpackage

//--- logic/credit_fifo.sv
// Small synchronous beat FIFO with show-ahead output; returns one credit pulse per popped entry
`timescale 1ns/1ps

module credit_fifo
  import mgt_stream_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic         bus_clk,
  input  logic         rst_n_i,
  input  logic         push_i,
  input  stream_beat_t push_beat_i,
  input  logic         pop_i,
  output stream_beat_t pop_beat_o,
  output logic         empty_o,
  output logic         full_o,
  output logic         credit_o
);

  // Depth of at least two assumed
  localparam int AW = $clog2(FIFO_DEPTH);

  stream_beat_t mem [FIFO_DEPTH];
  // Extra MSB tells full from empty
  logic [AW:0]  wr_ptr_q;
  logic [AW:0]  rd_ptr_q;
  logic         credit_q;

  always_ff @(posedge bus_clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      credit_q <= pop_i;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (push_i) begin
      mem[wr_ptr_q[AW-1:0]] <= push_beat_i;
    end
  end

  assign pop_beat_o = mem[rd_ptr_q[AW-1:0]];
  assign empty_o    = (wr_ptr_q == rd_ptr_q);
  assign full_o     = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                      (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
  assign credit_o   = credit_q;

  // Sender overran its credits
  a_push_full: assert property (
    @(posedge bus_clk) disable iff (!rst_n_i) push_i |-> !full_o
  ) else $error("push into full FIFO");

  a_pop_empty: assert property (
    @(posedge bus_clk) disable iff (!rst_n_i) pop_i |-> !empty_o
  ) else $error("pop from empty FIFO");

endmodule

//--- logic/regport_master.sv
// Host register front end; broadcasts one-cycle requests to all lanes and times out unclaimed reads
`timescale 1ns/1ps

module regport_master
  import regport_pkg::*;
#(
  parameter int TIMEOUT_LOG2 = 4
) (
  input  logic      bus_clk,
  input  logic      rst_n_i,
  input  host_req_t host_req_i,
  output logic      host_req_ready_o,
  output host_rsp_t host_rsp_o,
  output reg_req_t  reg_req_o,
  input  reg_rsp_t  reg_rsp_i
);

  typedef enum logic {
    IDLE,
    WAIT_RD
  } state_t;

  state_t                  state_q;
  logic                    ready_q;
  logic                    wr_pulse_q;
  logic                    rd_pulse_q;
  reg_addr_t               addr_q;
  reg_data_t               wr_data_q;
  logic [TIMEOUT_LOG2-1:0] wait_cnt_q;
  logic                    accept;
  logic                    timed_out;
  logic                    rd_done;

  assign accept    = host_req_i.valid && ready_q;
  // Counter starts at 1 on accept, so all ones marks 2^N-1 cycles
  assign timed_out = &wait_cnt_q;
  assign rd_done   = (state_q == WAIT_RD) && (reg_rsp_i.rd_resp || timed_out);

  // ----------------------------------------------------------
  // Request FSM
  // ----------------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      ready_q    <= 1'b0;
      wr_pulse_q <= 1'b0;
      rd_pulse_q <= 1'b0;
      wait_cnt_q <= '0;
    end else begin
      wr_pulse_q <= accept && host_req_i.write;
      rd_pulse_q <= accept && !host_req_i.write;
      case (state_q)
        IDLE: begin
          ready_q <= 1'b1;
          if (accept && !host_req_i.write) begin
            state_q    <= WAIT_RD;
            ready_q    <= 1'b0;
            wait_cnt_q <= TIMEOUT_LOG2'(1);
          end
        end
        WAIT_RD: begin
          wait_cnt_q <= wait_cnt_q + 1'b1;
          if (rd_done) begin
            state_q <= IDLE;
            ready_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address and data only matter alongside a pulse
  always_ff @(posedge bus_clk) begin
    if (accept) begin
      addr_q    <= host_req_i.addr;
      wr_data_q <= host_req_i.wr_data;
    end
  end

  assign host_req_ready_o  = ready_q;
  assign reg_req_o.wr_req  = wr_pulse_q;
  assign reg_req_o.rd_req  = rd_pulse_q;
  assign reg_req_o.addr    = addr_q;
  assign reg_req_o.wr_data = wr_data_q;

  // Lane data wins over a timeout landing on the same cycle
  assign host_rsp_o.valid   = rd_done;
  assign host_rsp_o.timeout = rd_done && !reg_rsp_i.rd_resp;
  assign host_rsp_o.rd_data = reg_rsp_i.rd_resp ? reg_rsp_i.rd_data : TIMEOUT_DATA;

  // A response must belong to an outstanding read
  a_no_stray_resp: assert property (
    @(posedge bus_clk) disable iff (!rst_n_i)
    reg_rsp_i.rd_resp |-> state_q == WAIT_RD
  ) else $error("read response with no read outstanding");

endmodule

//--- logic/regport_resp_mux.sv
// Merges the per-lane read responses into one registered response for the register master
`timescale 1ns/1ps

module regport_resp_mux
  import regport_pkg::*;
#(
  parameter int LANES = 2
) (
  input  logic     bus_clk,
  input  logic     rst_n_i,
  input  reg_rsp_t lane_rsp_i [LANES],
  output reg_rsp_t rsp_o
);

  logic [LANES-1:0] resp_vec;
  reg_data_t        data_or;
  logic             resp_q;
  reg_data_t        data_q;

  // Only a responding lane contributes data
  always_comb begin
    data_or = '0;
    for (int i = 0; i < LANES; i++) begin
      resp_vec[i] = lane_rsp_i[i].rd_resp;
      if (lane_rsp_i[i].rd_resp) begin
        data_or = data_or | lane_rsp_i[i].rd_data;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (!rst_n_i) begin
      resp_q <= 1'b0;
    end else begin
      resp_q <= |resp_vec;
    end
  end

  always_ff @(posedge bus_clk) begin
    data_q <= data_or;
  end

  assign rsp_o.rd_resp = resp_q;
  assign rsp_o.rd_data = data_q;

  // Lane address ranges must not overlap
  a_one_lane: assert property (
    @(posedge bus_clk) disable iff (!rst_n_i) $onehot0(resp_vec)
  ) else $error("more than one lane answered a read");

endmodule

//--- logic/mgt_lane.sv
// One transceiver lane: register block, transmit and receive queues, loopback and counters
`timescale 1ns/1ps

module mgt_lane
  import mgt_stream_pkg::*;
  import regport_pkg::*;
#(
  parameter int LANE_BASE   = 0,
  parameter int PORTNUM     = 0,
  parameter int FIFO_DEPTH  = 4,
  parameter int E2V_CREDITS = 2
) (
  input  logic         bus_clk,
  input  logic         rst_n_i,
  input  reg_req_t     reg_req_i,
  output reg_rsp_t     reg_rsp_o,
  input  stream_beat_t v2e_beat_i,
  output logic         v2e_credit_o,
  output stream_beat_t e2v_beat_o,
  input  logic         e2v_credit_i,
  output stream_beat_t gt_tx_o,
  input  stream_beat_t gt_rx_i,
  input  logic         gt_rx_locked_i,
  input  device_id_t   device_id_i,
  output logic         link_up_o,
  output logic         activity_o
);

  localparam reg_addr_t BASE_ADDR = reg_addr_t'(LANE_BASE);
  localparam int        CW        = $clog2(E2V_CREDITS + 1);

  // CTRL bit 1 is loopback, bit 0 is tx_enable
  typedef struct packed {
    logic loopback;
    logic tx_enable;
  } lane_ctrl_t;

  lane_ctrl_t   ctrl_q;
  reg_addr_t    rel_addr;
  logic         reg_hit;
  reg_data_t    rd_mux;
  logic         rd_resp_q;
  reg_data_t    rd_data_q;
  reg_data_t    tx_count_q;
  reg_data_t    rx_count_q;
  reg_data_t    drop_count_q;
  stream_beat_t tx_head;
  stream_beat_t rx_head;
  stream_beat_t rx_push_beat;
  logic         tx_empty, tx_pop, tx_credit;
  logic         rx_empty, rx_full, rx_push, rx_pop, rx_credit, rx_drop;
  logic [CW-1:0] e2v_cnt_q;

  function automatic reg_data_t sat_inc(reg_data_t v);
    return (&v) ? v : v + 1'b1;
  endfunction

  // ----------------------------------------------------------
  // Register block
  // ----------------------------------------------------------
  // Addresses below the base wrap high and miss
  assign rel_addr = reg_req_i.addr - BASE_ADDR;
  assign reg_hit  = rel_addr < reg_addr_t'(REG_BLOCK_SIZE);

  always_comb begin
    case (rel_addr)
      REG_CTRL:       rd_mux = {30'd0, ctrl_q};
      REG_STATUS:     rd_mux = {31'd0, link_up_o};
      REG_TX_COUNT:   rd_mux = tx_count_q;
      REG_RX_COUNT:   rd_mux = rx_count_q;
      REG_DROP_COUNT: rd_mux = drop_count_q;
      REG_PORT_INFO:  rd_mux = {8'd0, device_id_i, port_num_t'(PORTNUM)};
      default:        rd_mux = '0;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (!rst_n_i) begin
      ctrl_q       <= '0;
      rd_resp_q    <= 1'b0;
      tx_count_q   <= '0;
      rx_count_q   <= '0;
      drop_count_q <= '0;
    end else begin
      if (reg_req_i.wr_req && reg_hit && rel_addr == REG_CTRL) begin
        ctrl_q <= lane_ctrl_t'(reg_req_i.wr_data[1:0]);
      end
      rd_resp_q <= reg_req_i.rd_req && reg_hit;
      if (tx_pop) tx_count_q <= sat_inc(tx_count_q);
      if (rx_push) rx_count_q <= sat_inc(rx_count_q);
      if (rx_drop) drop_count_q <= sat_inc(drop_count_q);
    end
  end

  always_ff @(posedge bus_clk) begin
    rd_data_q <= rd_mux;
  end

  assign reg_rsp_o.rd_resp = rd_resp_q;
  assign reg_rsp_o.rd_data = rd_data_q;

  // ----------------------------------------------------------
  // Transmit path
  // ----------------------------------------------------------
  // Loopback waits for room rather than dropping
  assign tx_pop = !tx_empty && ctrl_q.tx_enable && !(ctrl_q.loopback && rx_full);

  credit_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) tx_fifo_i (
    .bus_clk     (bus_clk),
    .rst_n_i     (rst_n_i),
    .push_i      (v2e_beat_i.valid),
    .push_beat_i (v2e_beat_i),
    .pop_i       (tx_pop),
    .pop_beat_o  (tx_head),
    .empty_o     (tx_empty),
    .full_o      (),
    .credit_o    (tx_credit)
  );

  assign gt_tx_o.valid = tx_pop && !ctrl_q.loopback;
  assign gt_tx_o.last  = tx_head.last;
  assign gt_tx_o.data  = tx_head.data;
  assign v2e_credit_o  = tx_credit;

  // ----------------------------------------------------------
  // Receive path
  // ----------------------------------------------------------
  // Serial side has no back-pressure, overflow is dropped
  assign rx_drop = !ctrl_q.loopback && gt_rx_i.valid && rx_full;
  assign rx_push = ctrl_q.loopback ? tx_pop : (gt_rx_i.valid && !rx_full);

  always_comb begin
    rx_push_beat       = ctrl_q.loopback ? tx_head : gt_rx_i;
    rx_push_beat.valid = 1'b1;
  end

  assign rx_pop = !rx_empty && (e2v_cnt_q != '0);

  credit_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) rx_fifo_i (
    .bus_clk     (bus_clk),
    .rst_n_i     (rst_n_i),
    .push_i      (rx_push),
    .push_beat_i (rx_push_beat),
    .pop_i       (rx_pop),
    .pop_beat_o  (rx_head),
    .empty_o     (rx_empty),
    .full_o      (rx_full),
    .credit_o    (rx_credit)
  );

  // Router credits for the e2v direction
  always_ff @(posedge bus_clk) begin
    if (!rst_n_i) begin
      e2v_cnt_q <= CW'(E2V_CREDITS);
    end else begin
      e2v_cnt_q <= e2v_cnt_q + CW'(e2v_credit_i) - CW'(rx_pop);
    end
  end

  assign e2v_beat_o.valid = rx_pop;
  assign e2v_beat_o.last  = rx_head.last;
  assign e2v_beat_o.data  = rx_head.data;

  assign link_up_o  = gt_rx_locked_i || ctrl_q.loopback;
  assign activity_o = tx_credit || rx_credit;

  // Router must not return more credits than it was given
  a_e2v_credit_bound: assert property (
    @(posedge bus_clk) disable iff (!rst_n_i) e2v_cnt_q <= CW'(E2V_CREDITS)
  ) else $error("e2v credit count above its initial value");

endmodule

//--- logic/mgt_channel_array.sv
// Top level of the channel array; register front end, lanes in a generate loop and response mux
`timescale 1ns/1ps

module mgt_channel_array
  import mgt_stream_pkg::*;
  import regport_pkg::*;
#(
  parameter int LANES        = 2,
  parameter int REG_BASE     = 0,
  parameter int PORTNUM_BASE = 4,
  parameter int FIFO_DEPTH   = 4,
  parameter int E2V_CREDITS  = 2,
  parameter int TIMEOUT_LOG2 = 4
) (
  input  logic             bus_clk,
  input  logic             rst_n_i,
  // Host register port
  input  host_req_t        host_req_i,
  output logic             host_req_ready_o,
  output host_rsp_t        host_rsp_o,
  // Router side
  input  stream_beat_t     v2e_beat_i [LANES],
  output logic [LANES-1:0] v2e_credit_o,
  output stream_beat_t     e2v_beat_o [LANES],
  input  logic [LANES-1:0] e2v_credit_i,
  // Transceiver side
  output stream_beat_t     gt_tx_o [LANES],
  input  stream_beat_t     gt_rx_i [LANES],
  input  logic [LANES-1:0] gt_rx_locked_i,
  // Misc
  input  device_id_t       device_id_i,
  output logic [LANES-1:0] link_up_o,
  output logic [LANES-1:0] activity_o
);

  reg_req_t reg_req;
  reg_rsp_t lane_rsp [LANES];
  reg_rsp_t mux_rsp;

  // ----------------------------------------------------------
  // Register bus
  // ----------------------------------------------------------
  regport_master #(
    .TIMEOUT_LOG2 (TIMEOUT_LOG2)
  ) reg_mst_i (
    .bus_clk          (bus_clk),
    .rst_n_i          (rst_n_i),
    .host_req_i       (host_req_i),
    .host_req_ready_o (host_req_ready_o),
    .host_rsp_o       (host_rsp_o),
    .reg_req_o        (reg_req),
    .reg_rsp_i        (mux_rsp)
  );

  regport_resp_mux #(
    .LANES (LANES)
  ) reg_resp_mux_i (
    .bus_clk    (bus_clk),
    .rst_n_i    (rst_n_i),
    .lane_rsp_i (lane_rsp),
    .rsp_o      (mux_rsp)
  );

  // ----------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------
  for (genvar l = 0; l < LANES; l++) begin : g_lanes
    mgt_lane #(
      .LANE_BASE   (REG_BASE + l * REG_BLOCK_SIZE),
      .PORTNUM     (PORTNUM_BASE + l),
      .FIFO_DEPTH  (FIFO_DEPTH),
      .E2V_CREDITS (E2V_CREDITS)
    ) lane_i (
      .bus_clk        (bus_clk),
      .rst_n_i        (rst_n_i),
      .reg_req_i      (reg_req),
      .reg_rsp_o      (lane_rsp[l]),
      .v2e_beat_i     (v2e_beat_i[l]),
      .v2e_credit_o   (v2e_credit_o[l]),
      .e2v_beat_o     (e2v_beat_o[l]),
      .e2v_credit_i   (e2v_credit_i[l]),
      .gt_tx_o        (gt_tx_o[l]),
      .gt_rx_i        (gt_rx_i[l]),
      .gt_rx_locked_i (gt_rx_locked_i[l]),
      .device_id_i    (device_id_i),
      .link_up_o      (link_up_o[l]),
      .activity_o     (activity_o[l])
    );
  end

endmodule

//--- bench/mgt_channel_cases.svh
// Test table for the channel array bench, included inside the testbench module
// Columns are op, lane, register word address, value (write data or beat count), expected value
`ifndef MGT_CHANNEL_CASES_SVH
`define MGT_CHANNEL_CASES_SVH

localparam logic [2:0] OP_WRITE   = 3'd0;
localparam logic [2:0] OP_READ    = 3'd1;
localparam logic [2:0] OP_READ_TO = 3'd2;
localparam logic [2:0] OP_SEND    = 3'd3;
localparam logic [2:0] OP_STALL   = 3'd4;
localparam logic [2:0] OP_WAIT    = 3'd5;
localparam logic [2:0] OP_LINK    = 3'd6;
localparam logic [2:0] OP_INJECT  = 3'd7;

typedef struct packed {
  logic [2:0]  op;
  logic [1:0]  lane;
  logic [13:0] addr;
  logic [31:0] value;
  logic [31:0] expect_val;
} case_t;

localparam int NUM_CASES = 25;

// Lane 0 block at 0, lane 1 block at 16, port numbers 4 and 5, device id A5C3
localparam case_t CASES [NUM_CASES] = '{
  '{OP_READ,    2'd0, 14'd5,  32'd0, 32'h00A5_C304},
  '{OP_READ,    2'd0, 14'd21, 32'd0, 32'h00A5_C305},
  '{OP_READ_TO, 2'd0, 14'd40, 32'd0, 32'hDEAD_BEEF},
  '{OP_WRITE,   2'd0, 14'd0,  32'd1, 32'd0},
  '{OP_READ,    2'd0, 14'd0,  32'd0, 32'd1},
  '{OP_WRITE,   2'd1, 14'd16, 32'd1, 32'd0},
  '{OP_SEND,    2'd0, 14'd0,  32'd5, 32'd0},
  '{OP_SEND,    2'd1, 14'd0,  32'd3, 32'd0},
  '{OP_READ,    2'd0, 14'd2,  32'd0, 32'd5},
  '{OP_READ,    2'd1, 14'd18, 32'd0, 32'd3},
  // Back-pressure lets only the queue depth in
  '{OP_WRITE,   2'd0, 14'd0,  32'd0, 32'd0},
  '{OP_STALL,   2'd0, 14'd0,  32'd6, 32'd4},
  '{OP_WRITE,   2'd0, 14'd0,  32'd1, 32'd0},
  '{OP_WAIT,    2'd0, 14'd0,  32'd0, 32'd0},
  '{OP_READ,    2'd0, 14'd2,  32'd0, 32'd11},
  // Loopback on lane 0
  '{OP_WRITE,   2'd0, 14'd0,  32'd3, 32'd0},
  '{OP_LINK,    2'd0, 14'd0,  32'd0, 32'd1},
  '{OP_LINK,    2'd1, 14'd0,  32'd0, 32'd0},
  '{OP_SEND,    2'd0, 14'd0,  32'd6, 32'd0},
  '{OP_READ,    2'd0, 14'd3,  32'd0, 32'd6},
  '{OP_READ,    2'd0, 14'd1,  32'd0, 32'd1},
  // Two held credits plus a full queue survive and the rest drop
  '{OP_INJECT,  2'd1, 14'd0,  32'd8, 32'd6},
  '{OP_READ,    2'd1, 14'd20, 32'd0, 32'd2},
  '{OP_READ,    2'd1, 14'd19, 32'd0, 32'd6},
  '{OP_READ,    2'd1, 14'd18, 32'd0, 32'd3}
};

`endif

//--- bench/mgt_channel_tb.sv
// Testbench for the channel array; applies the case table and scoreboards both stream directions
`timescale 1ns/1ps

module mgt_channel_tb
  import mgt_stream_pkg::*;
  import regport_pkg::*;
;

  localparam int LANES        = 2;
  localparam int FIFO_DEPTH   = 4;
  localparam int E2V_CREDITS  = 2;
  localparam int TIMEOUT_LOG2 = 4;
  localparam int SEED         = 32'h214d55db;

  `include "mgt_channel_cases.svh"

  localparam int CYCLE_LIMIT = NUM_CASES * 64;

  logic             clk = 1'b0;
  logic             rst_n = 1'b0;
  host_req_t        host_req = '0;
  logic             host_req_ready_o;
  host_rsp_t        host_rsp_o;
  stream_beat_t     v2e_beat [LANES] = '{default: '0};
  logic [LANES-1:0] v2e_credit_o;
  stream_beat_t     e2v_beat_o [LANES];
  logic [LANES-1:0] e2v_credit = '0;
  stream_beat_t     gt_tx_o [LANES];
  stream_beat_t     gt_rx [LANES] = '{default: '0};
  logic [LANES-1:0] gt_rx_locked = '0;
  device_id_t       device_id = 16'hA5C3;
  logic [LANES-1:0] link_up_o;
  logic [LANES-1:0] activity_o;

  // Requests from the main sequence and counts kept by the stream model
  int send_req [LANES] = '{default: 0};
  int inj_req [LANES] = '{default: 0};
  int keep_req [LANES] = '{default: 0};
  bit hold [LANES] = '{default: 0};
  int sent [LANES] = '{default: 0};
  int inj_sent [LANES] = '{default: 0};
  int kept [LANES] = '{default: 0};
  int v2e_cred [LANES] = '{default: FIFO_DEPTH};
  int owed [LANES] = '{default: 0};
  int e2v_seen [LANES] = '{default: 0};
  int exp_in [LANES] = '{default: 0};
  int exp_out [LANES] = '{default: 0};
  bit popped_q [LANES] = '{default: 0};
  stream_beat_t exp_q [LANES][$];
  int main_err = 0;
  int mon_err = 0;
  int cycles = 0;

  mgt_channel_array #(
    .LANES (LANES), .REG_BASE (0), .PORTNUM_BASE (4), .FIFO_DEPTH (FIFO_DEPTH),
    .E2V_CREDITS (E2V_CREDITS), .TIMEOUT_LOG2 (TIMEOUT_LOG2)
  ) DUT (
    .bus_clk (clk), .rst_n_i (rst_n), .host_req_i (host_req),
    .host_req_ready_o (host_req_ready_o), .host_rsp_o (host_rsp_o),
    .v2e_beat_i (v2e_beat), .v2e_credit_o (v2e_credit_o), .e2v_beat_o (e2v_beat_o),
    .e2v_credit_i (e2v_credit), .gt_tx_o (gt_tx_o), .gt_rx_i (gt_rx),
    .gt_rx_locked_i (gt_rx_locked), .device_id_i (device_id),
    .link_up_o (link_up_o), .activity_o (activity_o)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp, output bit bad);
    bad = (got !== exp);
    if (bad) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Scoreboard compare for one beat leaving the DUT
  task automatic match_beat(input int l, input string port, input stream_beat_t got);
    stream_beat_t exp_beat;
    bit bad;
    if (exp_q[l].size() == 0) begin
      $display("Lane %0d sent a beat on %s at %0t when none was expected", l, port, $time);
      mon_err++;
    end else begin
      exp_beat = exp_q[l].pop_front();
      check_value({port, ".data"}, got.data, exp_beat.data, bad);
      mon_err += int'(bad);
      check_value({port, ".last"}, 64'(got.last), 64'(exp_beat.last), bad);
      mon_err += int'(bad);
    end
  endtask

  // ----------------------------------------------------------
  // Router and transceiver models
  // ----------------------------------------------------------
  always @(posedge clk) begin : stream_model
    stream_beat_t beat;
    int take;
    int give;
    int add_in;
    int add_out;
    bit bad;
    for (int l = 0; l < LANES; l++) begin
      take = 0;
      add_in = 0;
      add_out = 0;
      // Router only sends while it holds a v2e credit
      beat = '0;
      if (send_req[l] != sent[l] && v2e_cred[l] > 0) begin
        beat.valid = 1'b1;
        beat.last = (send_req[l] - sent[l] == 1);
        beat.data = {$urandom, $urandom};
        exp_q[l].push_back(beat);
        take = 1;
        add_in++;
      end
      v2e_beat[l] <= beat;
      sent[l] <= sent[l] + take;
      v2e_cred[l] <= v2e_cred[l] + int'(v2e_credit_o[l]) - take;
      // Serial side injects without back-pressure
      beat = '0;
      if (inj_req[l] != inj_sent[l]) begin
        beat.valid = 1'b1;
        beat.last = (inj_req[l] - inj_sent[l] == 1);
        beat.data = {$urandom, $urandom};
        inj_sent[l] <= inj_sent[l] + 1;
        if (kept[l] != keep_req[l]) begin
          exp_q[l].push_back(beat);
          kept[l] <= kept[l] + 1;
          add_in++;
        end
      end
      gt_rx[l] <= beat;
      if (gt_tx_o[l].valid) begin
        match_beat(l, "gt_tx", gt_tx_o[l]);
        add_out++;
      end
      if (e2v_beat_o[l].valid) begin
        match_beat(l, "e2v", e2v_beat_o[l]);
        add_out++;
      end
      // Activity pulses in the cycle after a pop
      // A transmit pop in loopback shows only as a returned v2e credit
      if (rst_n) begin
        check_value("activity", 64'(activity_o[l]),
                    64'(popped_q[l] || v2e_credit_o[l]), bad);
        mon_err += int'(bad);
      end
      popped_q[l] <= gt_tx_o[l].valid || e2v_beat_o[l].valid;
      e2v_seen[l] <= e2v_seen[l] + int'(e2v_beat_o[l].valid);
      give = (!hold[l] && owed[l] > 0) ? 1 : 0;
      e2v_credit[l] <= (give == 1);
      owed[l] <= owed[l] + int'(e2v_beat_o[l].valid) - give;
      exp_in[l] <= exp_in[l] + add_in;
      exp_out[l] <= exp_out[l] + add_out;
    end
  end

  task automatic reg_write(input reg_addr_t a, input reg_data_t d);
    @(posedge clk);
    while (!host_req_ready_o) @(posedge clk);
    host_req <= '{valid: 1'b1, write: 1'b1, addr: a, wr_data: d};
    @(posedge clk);
    host_req <= '0;
  endtask

  task automatic reg_read(input reg_addr_t a, output reg_data_t d, output bit to);
    @(posedge clk);
    while (!host_req_ready_o) @(posedge clk);
    host_req <= '{valid: 1'b1, write: 1'b0, addr: a, wr_data: '0};
    @(posedge clk);
    host_req <= '0;
    do @(posedge clk); while (!host_rsp_o.valid);
    d = host_rsp_o.rd_data;
    to = host_rsp_o.timeout;
  endtask

  // Idle once every beat is delivered and all credits are home
  task automatic wait_idle(input int l);
    do @(posedge clk);
    while (sent[l] != send_req[l] || inj_sent[l] != inj_req[l] ||
           exp_in[l] != exp_out[l] || owed[l] != 0 || v2e_cred[l] != FIFO_DEPTH);
  endtask

  task automatic run_case(input case_t c);
    reg_data_t rd;
    bit to;
    bit bad;
    int base;
    int l;
    int keep;
    l = int'(c.lane);
    case (c.op)
      OP_WRITE: reg_write(c.addr, c.value);
      OP_READ, OP_READ_TO: begin
        reg_read(c.addr, rd, to);
        check_value("host_rsp.rd_data", 64'(rd), 64'(c.expect_val), bad);
        main_err += int'(bad);
        check_value("host_rsp.timeout", 64'(to), 64'(c.op == OP_READ_TO), bad);
        main_err += int'(bad);
      end
      OP_SEND: begin
        send_req[l] <= send_req[l] + int'(c.value);
        wait_idle(l);
      end
      OP_STALL: begin
        base = sent[l];
        send_req[l] <= send_req[l] + int'(c.value);
        do @(posedge clk); while (v2e_cred[l] != 0);
        repeat (4) @(posedge clk);
        check_value("v2e beats accepted", 64'(sent[l] - base), 64'(c.expect_val), bad);
        main_err += int'(bad);
      end
      OP_WAIT: wait_idle(l);
      OP_LINK: begin
        repeat (2) @(posedge clk);
        check_value("link_up", 64'(link_up_o[l]), 64'(c.expect_val), bad);
        main_err += int'(bad);
      end
      default: begin
        base = e2v_seen[l];
        keep = (int'(c.value) < E2V_CREDITS + FIFO_DEPTH) ? int'(c.value) :
               E2V_CREDITS + FIFO_DEPTH;
        hold[l] <= 1'b1;
        inj_req[l] <= inj_req[l] + int'(c.value);
        keep_req[l] <= keep_req[l] + keep;
        do @(posedge clk); while (inj_sent[l] != inj_req[l]);
        repeat (4) @(posedge clk);
        check_value("e2v beats on held credits", 64'(e2v_seen[l] - base),
                    64'(E2V_CREDITS), bad);
        main_err += int'(bad);
        hold[l] <= 1'b0;
        wait_idle(l);
        check_value("e2v beats delivered", 64'(e2v_seen[l] - base), 64'(c.expect_val), bad);
        main_err += int'(bad);
      end
    endcase
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    int errs_before;
    int failing;
    failing = 0;
    void'($urandom(SEED));
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_CASES; i++) begin
      errs_before = main_err + mon_err;
      run_case(CASES[i]);
      if (main_err + mon_err != errs_before) begin
        failing++;
      end
      $display("test %0d op %0d lane %0d: %s", i, CASES[i].op, CASES[i].lane,
               (main_err + mon_err == errs_before) ? "ok" : "FAILED");
    end
    $display("summary: %0d tests run, %0d failing, %0d mismatches",
             NUM_CASES, failing, main_err + mon_err);
    if (main_err + mon_err == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Guard against a stuck handshake
  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("tests failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+bench
logic/mgt_stream_pkg.sv
logic/regport_pkg.sv
logic/credit_fifo.sv
logic/regport_master.sv
logic/regport_resp_mux.sv
logic/mgt_lane.sv
logic/mgt_channel_array.sv
bench/mgt_channel_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run the channel array testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mgt_channel_tb \
  -f filelist.f -o mgt_channel_sim > build.log 2>&1 \
  && ./obj_dir/mgt_channel_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && { echo "RESULT: FAIL"; exit 1; } \
  || { echo "RESULT: PASS"; exit 0; }
